//--- event_pkg.sv
package event_pkg;

    // detector channels served by the serializer
    localparam int num_channels = 6;

    // event kinds; declaration order is also arbitration priority
    typedef enum logic [1:0] {
        kind_hit   = 2'd0,
        kind_line  = 2'd1,
        kind_frame = 2'd2
    } event_kind_t;

    // record tags on the serial link
    // tdc timing hit
    localparam logic [15:0] tag_hit   = 16'h00D4;
    // mirror new-line
    localparam logic [15:0] tag_line  = 16'h000D;
    // mirror new-frame
    localparam logic [15:0] tag_frame = 16'h000E;

    // one record on the link, sent lsb byte first
    typedef struct packed {
        // kind tag
        logic [15:0] tag_hi;
        // copy of tag_hi, lets the host check framing
        logic [15:0] tag_lo;
        // 1-based channel number
        logic [15:0] channel_id;
    } record_t;

    // zero-based channel index
    typedef logic [2:0] chan_idx_t;

endpackage

//--- channel_slot.sv
`timescale 1ns/1ps

module channel_slot (
    input  logic                   clk,
    input  logic                   rst,
    // detector side, valid/ready
    input  logic                   ev_valid,
    input  event_pkg::event_kind_t ev_kind,
    output logic                   ev_ready,
    // arbiter side
    input  logic                   grant,
    output logic                   pending,
    output event_pkg::event_kind_t kind
);

    // empty slot is the only condition for accepting
    assign ev_ready = ~pending;

    // occupancy flag
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (pending) begin
            // held until the arbiter takes it
            if (grant) begin
                pending <= 1'b0;
            end
        end else if (ev_valid) begin
            pending <= 1'b1;
        end
    end

    // kind of the held event
    // loaded only on accept, stable while pending
    always_ff @(posedge clk) begin
        if (ev_valid && ev_ready) begin
            kind <= ev_kind;
        end
    end

endmodule

//--- event_arbiter.sv
`timescale 1ns/1ps

module event_arbiter (
    // per-channel requests from the slots
    input  logic [event_pkg::num_channels-1:0] pending,
    input  event_pkg::event_kind_t             kind [event_pkg::num_channels],
    output logic [event_pkg::num_channels-1:0] grant,
    // write side of the record fifo
    output logic                               wr_valid,
    input  logic                               wr_ready,
    output event_pkg::record_t                 wr_record
);

    import event_pkg::*;

    logic        found;
    chan_idx_t   win_idx;
    event_kind_t win_kind;
    logic [15:0] win_tag;

    // tag code per kind
    function automatic logic [15:0] tag_of(input event_kind_t k);
        logic [15:0] t;
        unique case (k)
            kind_hit:   t = tag_hit;
            kind_line:  t = tag_line;
            default:    t = tag_frame;
        endcase
        return t;
    endfunction

    // winner search
    // lower enum value wins, strict compare keeps the lower channel on a tie
    always_comb begin
        found    = 1'b0;
        win_idx  = '0;
        win_kind = kind_hit;
        for (int c = 0; c < num_channels; c++) begin
            if (pending[c] && (!found || kind[c] < win_kind)) begin
                found    = 1'b1;
                win_idx  = chan_idx_t'(c);
                win_kind = kind[c];
            end
        end
    end

    // one-hot grant, only when the fifo can take the record
    always_comb begin
        grant = '0;
        if (found && wr_ready) begin
            grant[win_idx] = 1'b1;
        end
    end

    assign wr_valid = found;
    assign win_tag  = tag_of(win_kind);

    // record assembly
    // channel numbers on the link start at 1
    always_comb begin
        wr_record.tag_hi     = win_tag;
        wr_record.tag_lo     = win_tag;
        wr_record.channel_id = 16'(win_idx) + 16'd1;
    end

endmodule

//--- record_fifo.sv
`timescale 1ns/1ps

module record_fifo #(
    // power of two, at least 2
    parameter int fifo_depth = 8
) (
    input  logic               clk,
    input  logic               rst,
    // write side
    input  logic               wr_valid,
    output logic               wr_ready,
    input  event_pkg::record_t wr_record,
    // read side, head shown without a read request
    output logic               rd_valid,
    input  logic               rd_ready,
    output event_pkg::record_t rd_record,
    output logic               full
);

    import event_pkg::*;

    localparam int addr_w = $clog2(fifo_depth);

    record_t           mem [fifo_depth];
    // extra msb tells a full buffer from an empty one
    logic [addr_w:0]   wr_ptr;
    logic [addr_w:0]   rd_ptr;
    logic              empty;
    logic              do_wr;
    logic              do_rd;

    // equal pointers mean empty
    // same address with differing wrap bit means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    assign wr_ready = ~full;
    assign rd_valid = ~empty;
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;

    // fall-through head, valid the cycle after the write
    assign rd_record = mem[rd_ptr[addr_w-1:0]];

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[addr_w-1:0]] <= wr_record;
        end
    end

    // pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // pop on the handshake edge
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- uart_record_tx.sv
`timescale 1ns/1ps

module uart_record_tx #(
    // clock cycles per serial bit
    parameter int clk_per_bit = 4
) (
    input  logic               clk,
    input  logic               rst,
    // head of the record fifo
    input  logic               rd_valid,
    output logic               rd_ready,
    input  event_pkg::record_t rd_record,
    // serial line, idles high
    output logic               tx,
    output logic               busy
);

    localparam int num_bytes = 6;
    localparam int cnt_w     = (clk_per_bit > 1) ? $clog2(clk_per_bit) : 1;

    logic             busy_q;
    // bytes still to send, current one in the low byte
    logic [47:0]      data_q;
    // stop, data lsb first, start; bit 0 is on the line
    logic [9:0]       bit_sr;
    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [2:0]       byte_cnt;
    logic             bit_end;
    logic             take;

    // accepts only between frames
    assign rd_ready = ~busy_q;
    assign take     = rd_valid && rd_ready;
    assign busy     = busy_q;
    assign tx       = busy_q ? bit_sr[0] : 1'b1;
    assign bit_end  = (clk_cnt == cnt_w'(clk_per_bit - 1));

    // control: frame flag and the three timing counters
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= 1'b0;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (!busy_q) begin
            if (take) begin
                busy_q   <= 1'b1;
                clk_cnt  <= '0;
                bit_cnt  <= '0;
                byte_cnt <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                bit_cnt <= '0;
                // stop bit of the last byte ends the frame
                if (byte_cnt == 3'(num_bytes - 1)) begin
                    busy_q <= 1'b0;
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // payload shifters
    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= rd_record;
            bit_sr <= {1'b1, rd_record[7:0], 1'b0};
        end else if (busy_q && bit_end) begin
            if (bit_cnt == 4'd9) begin
                // next byte, lsb byte of the record went first
                data_q <= data_q >> 8;
                bit_sr <= {1'b1, data_q[15:8], 1'b0};
            end else begin
                bit_sr <= {1'b1, bit_sr[9:1]};
            end
        end
    end

endmodule

//--- event_serializer_top.sv
`timescale 1ns/1ps

module event_serializer_top #(
    parameter int clk_per_bit = 4,
    parameter int fifo_depth  = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    // detector events, one valid/ready pair per channel
    input  logic [event_pkg::num_channels-1:0] ev_valid,
    input  event_pkg::event_kind_t             ev_kind [event_pkg::num_channels],
    output logic [event_pkg::num_channels-1:0] ev_ready,
    // serial link and status
    output logic                               tx,
    output logic                               tx_busy,
    output logic                               fifo_full
);

    import event_pkg::*;

    logic [num_channels-1:0] pending;
    logic [num_channels-1:0] grant;
    event_kind_t             kind [num_channels];

    // arbiter to fifo
    logic    wr_valid;
    logic    wr_ready;
    record_t wr_record;

    // fifo to transmitter
    logic    rd_valid;
    logic    rd_ready;
    record_t rd_record;

    // one holding slot per detector channel
    for (genvar i = 0; i < num_channels; i++) begin : g_slot
        channel_slot slot_i (
            .clk      (clk),
            .rst      (rst),
            .ev_valid (ev_valid[i]),
            .ev_kind  (ev_kind[i]),
            .ev_ready (ev_ready[i]),
            .grant    (grant[i]),
            .pending  (pending[i]),
            .kind     (kind[i])
        );
    end

    // hit, line, frame; lower channel first
    event_arbiter arb_i (
        .pending   (pending),
        .kind      (kind),
        .grant     (grant),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_record (wr_record)
    );

    record_fifo #(
        .fifo_depth (fifo_depth)
    ) fifo_i (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_record (wr_record),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_record (rd_record),
        .full      (fifo_full)
    );

    // drains the fifo whenever idle
    uart_record_tx #(
        .clk_per_bit (clk_per_bit)
    ) tx_i (
        .clk       (clk),
        .rst       (rst),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_record (rd_record),
        .tx        (tx),
        .busy      (tx_busy)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int clk_per_bit = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [event_pkg::num_channels-1:0] ev_valid,
    input  event_pkg::event_kind_t             ev_kind [event_pkg::num_channels],
    input  logic [event_pkg::num_channels-1:0] ev_ready,
    input  logic                               tx,
    input  logic                               tx_busy,
    input  logic                               fifo_full,
    // compare outputs against their post-reset values
    input  logic                               expect_idle,
    // a six-channel burst on this edge gets its drain order checked
    input  logic                               order_check,
    output int                                 check_count,
    output int                                 error_count,
    output int                                 outstanding
);

    import event_pkg::*;

    // accepted events not yet seen on tx as {tag, tag, channel id}
    logic [47:0]             exp_q [$];
    // channel ids of a burst in expected drain order
    int                      order_q [$];
    // records still ahead of the burst
    int                      order_skip = 0;
    string                   cur_test = "none";
    int                      checks_at_start;
    int                      errors_at_start;
    logic                    rst_seen = 1'b0;
    logic [num_channels-1:0] just_acc = '0;

    // tag codes of the link format
    function automatic logic [15:0] expected_tag(input event_kind_t k);
        if (k == kind_hit) begin
            return 16'h00D4;
        end else if (k == kind_line) begin
            return 16'h000D;
        end else begin
            return 16'h000E;
        end
    endfunction

    task automatic compare(input string what, input logic [47:0] exp, input logic [47:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("mismatch in test %s, %s: expected %0h, actual %0h",
                     cur_test, what, exp, act);
        end
    endtask

    task automatic report(input string msg);
        error_count++;
        $display("error in test %s: %s", cur_test, msg);
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        if (exp_q.size() != 0) begin
            report($sformatf("%0d accepted events never came out on tx", exp_q.size()));
        end
        if (order_q.size() != 0) begin
            report($sformatf("%0d records of the burst never came out", order_q.size()));
            order_q.delete();
        end
        $display("test %s: %0d checks, %0d errors", name,
                 check_count - checks_at_start, error_count - errors_at_start);
    endtask

    task automatic check_record(input logic [47:0] rec);
        int ch;
        int idx;
        ch  = int'(rec[15:0]);
        idx = -1;
        if (ch < 1 || ch > num_channels) begin
            report($sformatf("record with unknown channel id %0d", ch));
        end else begin
            // oldest waiting event of that channel
            for (int k = 0; k < exp_q.size(); k++) begin
                if (idx < 0 && exp_q[k][15:0] == rec[15:0]) begin
                    idx = k;
                end
            end
            if (idx < 0) begin
                report($sformatf("record for channel %0d with no accepted event", ch));
            end else begin
                compare($sformatf("record on channel %0d", ch), exp_q[idx], rec);
                exp_q.delete(idx);
                outstanding = exp_q.size();
            end
            if (order_q.size() > 0) begin
                if (order_skip > 0) begin
                    order_skip--;
                end else begin
                    compare("burst drain order, channel", 48'(order_q[0]), 48'(ch));
                    void'(order_q.pop_front());
                end
            end
        end
    endtask

    // model update on the accepting edge
    always @(posedge clk) begin
        logic [num_channels-1:0] acc;
        if (rst) begin
            rst_seen = 1'b1;
        end
        acc      = rst ? '0 : (ev_valid & ev_ready);
        just_acc = acc;
        if (order_check && acc == '1) begin
            // everything already queued drains first
            order_skip = exp_q.size();
            for (int k = 0; k < 3; k++) begin
                for (int i = 0; i < num_channels; i++) begin
                    if (ev_kind[i] == event_kind_t'(k)) begin
                        order_q.push_back(i + 1);
                    end
                end
            end
        end
        for (int i = 0; i < num_channels; i++) begin
            if (acc[i]) begin
                exp_q.push_back({expected_tag(ev_kind[i]), expected_tag(ev_kind[i]),
                                 16'(i + 1)});
            end
        end
        outstanding = exp_q.size();
    end

    // state checks half a cycle after the edge
    always @(negedge clk) begin
        if (expect_idle && rst_seen) begin
            compare("tx idle level", 48'(1'b1), 48'(tx));
            compare("tx_busy", '0, 48'(tx_busy));
            compare("fifo_full", '0, 48'(fifo_full));
            compare("ev_ready", 48'(6'h3f), 48'(ev_ready));
        end
        // an accepted event always occupies its slot for a cycle
        for (int i = 0; i < num_channels; i++) begin
            if (just_acc[i]) begin
                compare($sformatf("ev_ready[%0d] after accept", i), '0, 48'(ev_ready[i]));
            end
        end
    end

    // serial decoder sampling at mid-bit
    initial begin
        logic [7:0]  byte_v;
        logic [47:0] rec;
        int          nbytes;
        nbytes = 0;
        rec    = '0;
        forever begin
            @(negedge clk);
            if (!rst && tx === 1'b0) begin
                repeat (clk_per_bit / 2) @(negedge clk);
                if (tx !== 1'b0) begin
                    report("start bit on tx shorter than half a bit");
                end else begin
                    // busy covers every byte of the frame
                    compare("tx_busy during a frame", 48'(1'b1), 48'(tx_busy));
                    for (int b = 0; b < 8; b++) begin
                        repeat (clk_per_bit) @(negedge clk);
                        byte_v[b] = tx;
                    end
                    repeat (clk_per_bit) @(negedge clk);
                    if (tx !== 1'b1) begin
                        report("stop bit missing on tx");
                    end
                    // lsb byte of the record arrives first
                    rec = {byte_v, rec[47:8]};
                    nbytes++;
                    if (nbytes == 6) begin
                        check_record(rec);
                        nbytes = 0;
                    end
                end
            end
        end
    end

endmodule

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top;

    import event_pkg::*;

    localparam int clk_per_bit = 4;
    localparam int fifo_depth  = 8;
    localparam int num_random  = 200;
    // single, random, two fifo fills with slack, one burst
    localparam int num_events  = 3 * num_channels + num_random + 2 * fifo_depth + 12;
    localparam int timeout_ns  = num_events * 60 * clk_per_bit * 4 * 2 + 2000;
    localparam event_kind_t burst_kind [num_channels] =
        '{kind_frame, kind_line, kind_hit, kind_frame, kind_hit, kind_line};

    logic                    clk;
    logic                    rst;
    logic [num_channels-1:0] ev_valid;
    logic [num_channels-1:0] ev_ready;
    logic [num_channels-1:0] accepted;
    event_kind_t             ev_kind [num_channels];
    logic                    tx;
    logic                    tx_busy;
    logic                    fifo_full;
    logic                    expect_idle;
    logic                    order_check;
    int                      check_count;
    int                      error_count;
    int                      outstanding;
    logic [31:0]             rng;

    tb_clock_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    event_serializer_top #(
        .clk_per_bit (clk_per_bit),
        .fifo_depth  (fifo_depth)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .ev_valid  (ev_valid),
        .ev_kind   (ev_kind),
        .ev_ready  (ev_ready),
        .tx        (tx),
        .tx_busy   (tx_busy),
        .fifo_full (fifo_full)
    );

    tb_checker #(
        .clk_per_bit (clk_per_bit)
    ) chk_i (
        .clk         (clk),
        .rst         (rst),
        .ev_valid    (ev_valid),
        .ev_kind     (ev_kind),
        .ev_ready    (ev_ready),
        .tx          (tx),
        .tx_busy     (tx_busy),
        .fifo_full   (fifo_full),
        .expect_idle (expect_idle),
        .order_check (order_check),
        .check_count (check_count),
        .error_count (error_count),
        .outstanding (outstanding)
    );

    // handshakes completed on the last rising edge
    always @(posedge clk) begin
        accepted <= ev_valid & ev_ready;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic event_kind_t kind_of(input logic [31:0] r);
        return event_kind_t'(2'(r % 3));
    endfunction

    // hold valid until the slot takes the event
    task automatic send_event(input int ch, input event_kind_t k);
        ev_valid[ch] = 1'b1;
        ev_kind[ch]  = k;
        do begin
            @(negedge clk);
        end while (!accepted[ch]);
        ev_valid[ch] = 1'b0;
    endtask

    task automatic wait_drain();
        int limit;
        int n;
        limit = (outstanding + 2) * 60 * clk_per_bit + 100;
        n     = 0;
        while (outstanding != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        // last stop bit
        repeat (2 * clk_per_bit) @(negedge clk);
    endtask

    initial begin
        int n;
        ev_valid    = '0;
        expect_idle = 1'b1;
        order_check = 1'b0;
        rng         = 32'd3;
        for (int ch = 0; ch < num_channels; ch++) begin
            ev_kind[ch] = kind_hit;
        end
        chk_i.begin_test("reset");
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        @(posedge clk);
        expect_idle = 1'b0;
        @(negedge clk);
        chk_i.end_test("reset");

        // every kind on every channel with one record in flight at a time
        chk_i.begin_test("single");
        for (int k = 0; k < 3; k++) begin
            for (int ch = 0; ch < num_channels; ch++) begin
                send_event(ch, event_kind_t'(k));
                wait_drain();
            end
        end
        chk_i.end_test("single");

        // each idle channel starts an event with chance one in four per cycle
        chk_i.begin_test("random");
        n = 0;
        while (n < num_random || ev_valid != '0) begin
            @(negedge clk);
            ev_valid = ev_valid & ~accepted;
            for (int ch = 0; ch < num_channels; ch++) begin
                rng = xorshift(rng);
                if (!ev_valid[ch] && n < num_random && rng[1:0] == 2'd0) begin
                    rng          = xorshift(rng);
                    ev_valid[ch] = 1'b1;
                    ev_kind[ch]  = kind_of(rng);
                    n++;
                end
            end
        end
        wait_drain();
        chk_i.end_test("random");

        chk_i.begin_test("backpressure");
        n = 0;
        while (!fifo_full && n < 4 * fifo_depth) begin
            rng = xorshift(rng);
            send_event(0, kind_of(rng));
            @(negedge clk);
            n++;
        end
        if (!fifo_full) begin
            chk_i.report("fifo_full never rose under back-pressure");
        end else begin
            rng = xorshift(rng);
            send_event(0, kind_of(rng));
            // a full fifo keeps the slot occupied
            if (fifo_full) begin
                @(negedge clk);
                chk_i.compare("ev_ready[0] while fifo full", '0, 48'(ev_ready[0]));
            end
        end
        wait_drain();
        chk_i.end_test("backpressure");

        // refill until the fifo is full and every slot is empty
        chk_i.begin_test("priority");
        n = 0;
        while (!(fifo_full && ev_ready == '1) && n < 8 * fifo_depth) begin
            if (!fifo_full && ev_ready[0]) begin
                rng = xorshift(rng);
                send_event(0, kind_of(rng));
                n++;
            end
            @(negedge clk);
        end
        order_check = 1'b1;
        for (int ch = 0; ch < num_channels; ch++) begin
            ev_kind[ch] = burst_kind[ch];
        end
        ev_valid = '1;
        @(negedge clk);
        ev_valid    = '0;
        order_check = 1'b0;
        if (accepted != '1) begin
            chk_i.report("burst was not taken by all six slots on one edge");
        end
        wait_drain();
        chk_i.end_test("priority");

        $display("totals: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_ns);
        $display("watchdog: run did not finish within %0d ns", timeout_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- filelist.f
event_pkg.sv
channel_slot.sv
event_arbiter.sv
record_fifo.sv
uart_record_tx.sv
event_serializer_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_top
FILELIST  := filelist.f
BUILD     := obj_dir
LOG       := sim.log

SIM := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || echo "CHECKS FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
